// ==== verilog/simon_macros.svh ====
`ifndef SIMON_MACROS_SVH
`define SIMON_MACROS_SVH

// cycles a synchronized button must stay unchanged before the held level follows it
`define SIMON_DEBOUNCE_CYCLES 8

// one playback slot; on the board this would be one second of clock
`define SIMON_TONE_CYCLES 40

// lit part of a slot, three quarters of it
`define SIMON_TONE_ON_CYCLES 30

// galois lfsr for the color stream
`define SIMON_LFSR_WIDTH 16

// must be nonzero, the lfsr never leaves the all-zero state
`define SIMON_LFSR_SEED 16'hACE1

// score and the counters that compare against it
`define SIMON_SCORE_WIDTH 8

`endif

// ==== verilog/simon_pkg.sv ====
`default_nettype none

`include "simon_macros.svh"

package simonPkg;

	// game FSM states
	typedef enum logic [3:0] {
		IDLE           = 4'd0,
		RANDOMIZE      = 4'd1,
		SIMON_PLAY     = 4'd2,
		PLAYER_INIT    = 4'd3,
		PLAYER_ENTRY   = 4'd4,
		PLAYER_RELEASE = 4'd5,
		PLAYER_CHECK   = 4'd6,
		PLAYER_LOSE    = 4'd7
	} gameState_t;

	// colors match the button layout
	typedef enum logic [1:0] {
		GREEN  = 2'd0,
		RED    = 2'd1,
		YELLOW = 2'd2,
		BLUE   = 2'd3
	} color_t;

	typedef logic [`SIMON_SCORE_WIDTH-1:0] score_t;

endpackage

`default_nettype wire

// ==== verilog/buttonDebouncer.sv ====
`default_nettype none

`include "simon_macros.svh"

module buttonDebouncer (
	input  wire  clk,
	input  wire  reset,
	input  wire  button,
	output logic held
);

	localparam int unsigned StableCycles = `SIMON_DEBOUNCE_CYCLES;
	localparam int unsigned CountWidth = $clog2(StableCycles + 1);

	logic syncMeta;
	logic syncLevel;
	logic lastLevel;
	logic [CountWidth-1:0] stableCount;
	logic isStable;

	assign isStable = (stableCount == CountWidth'(StableCycles));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			syncMeta <= 1'b0;
			syncLevel <= 1'b0;
			lastLevel <= 1'b0;
			stableCount <= '0;
			held <= 1'b0;
		end else begin
			// two-flop synchronizer for the raw switch
			syncMeta <= button;
			syncLevel <= syncMeta;
			lastLevel <= syncLevel;
			// any edge restarts the count, otherwise count up and stop at the limit
			if (syncLevel != lastLevel) begin
				stableCount <= '0;
			end else if (!isStable) begin
				stableCount <= stableCount + 1'b1;
			end
			if (isStable) begin
				held <= lastLevel;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sequenceGenerator.sv ====
`default_nettype none

`include "simon_macros.svh"

module sequenceGenerator
	import simonPkg::*;
(
	input  wire    clk,
	input  wire    reset,
	input  wire    stepSequence,
	input  wire    captureSeed,
	input  wire    rerunSequence,
	output color_t color
);

	localparam int unsigned LfsrWidth = `SIMON_LFSR_WIDTH;

	// x^16 + x^14 + x^13 + x^11 + 1, maximal length
	localparam logic [LfsrWidth-1:0] Taps = LfsrWidth'(16'hB400);
	localparam logic [LfsrWidth-1:0] ResetSeed = LfsrWidth'(`SIMON_LFSR_SEED);

	logic [LfsrWidth-1:0] lfsrState;
	logic [LfsrWidth-1:0] seedState;
	logic [LfsrWidth-1:0] lfsrNext;

	// galois form shifts right and folds the dropped bit into the taps
	always_comb begin
		lfsrNext = {1'b0, lfsrState[LfsrWidth-1:1]};
		if (lfsrState[0]) begin
			lfsrNext = lfsrNext ^ Taps;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			lfsrState <= ResetSeed;
			seedState <= ResetSeed;
		end else begin
			// rerun wins over a step in the same cycle
			if (rerunSequence) begin
				lfsrState <= seedState;
			end else if (stepSequence) begin
				lfsrState <= lfsrNext;
			end
			// round seed, replayed from the start of every round
			if (captureSeed) begin
				seedState <= lfsrState;
			end
		end
	end

	assign color = color_t'(lfsrState[1:0]);

endmodule

`default_nettype wire

// ==== verilog/toneTimer.sv ====
`default_nettype none

`include "simon_macros.svh"

module toneTimer (
	input  wire  clk,
	input  wire  reset,
	input  wire  slotEnable,
	output logic slotDone,
	output logic toneWindow
);

	localparam int unsigned SlotCycles = `SIMON_TONE_CYCLES;
	localparam int unsigned OnCycles = `SIMON_TONE_ON_CYCLES;
	localparam int unsigned CountWidth = $clog2(SlotCycles);

	logic [CountWidth-1:0] slotCount;
	logic slotEnd;

	assign slotEnd = (slotCount == CountWidth'(SlotCycles - 1));

	// counter sits at zero while disabled so the first slot starts lit
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			slotCount <= '0;
		end else if (!slotEnable || slotEnd) begin
			slotCount <= '0;
		end else begin
			slotCount <= slotCount + 1'b1;
		end
	end

	// last cycle of a slot, back-to-back slots follow with no gap
	assign slotDone = slotEnable && slotEnd;

	// lit for the first part of the slot, dark for the rest
	assign toneWindow = slotEnable && (slotCount < CountWidth'(OnCycles));

endmodule

`default_nettype wire

// ==== verilog/gameController.sv ====
`default_nettype none

module gameController
	import simonPkg::*;
(
	input  wire    clk,
	input  wire    reset,
	input  wire    heldGreen,
	input  wire    heldRed,
	input  wire    heldYellow,
	input  wire    heldBlue,
	input  wire    color_t color,
	input  wire    slotDone,
	input  wire    toneWindow,
	output logic   stepSequence,
	output logic   captureSeed,
	output logic   rerunSequence,
	output logic   slotEnable,
	output logic   lampOn,
	output logic   toneOn,
	output logic   awaitingPlayer,
	output color_t lampColor,
	output score_t score
);

	gameState_t state;
	gameState_t nextState;
	color_t entryColor;
	color_t pressedColor;
	score_t playedCount;
	score_t entryCount;
	logic anyHeld;
	logic entryMatch;
	logic lastSlot;
	logic roundComplete;

	assign anyHeld = heldGreen | heldRed | heldYellow | heldBlue;

	// with several buttons down the entry resolves green, yellow, red, blue
	always_comb begin
		if (heldGreen) begin
			pressedColor = GREEN;
		end else if (heldYellow) begin
			pressedColor = YELLOW;
		end else if (heldRed) begin
			pressedColor = RED;
		end else begin
			pressedColor = BLUE;
		end
	end

	assign entryMatch = (entryColor == color);
	// a round plays and expects score+1 colors
	assign lastSlot = (playedCount == score);
	assign roundComplete = (entryCount == score);

	always_comb begin
		nextState = state;
		stepSequence = 1'b0;
		captureSeed = 1'b0;
		rerunSequence = 1'b0;
		case (state)
			IDLE: begin
				if (heldGreen) begin
					nextState = RANDOMIZE;
				end
			end
			RANDOMIZE: begin
				// free-running lfsr while green is held, hold time picks the seed
				if (heldGreen) begin
					stepSequence = 1'b1;
				end else begin
					captureSeed = 1'b1;
					nextState = SIMON_PLAY;
				end
			end
			SIMON_PLAY: begin
				if (slotDone) begin
					stepSequence = 1'b1;
					if (lastSlot) begin
						nextState = PLAYER_INIT;
					end
				end
			end
			PLAYER_INIT: begin
				rerunSequence = 1'b1;
				nextState = PLAYER_ENTRY;
			end
			PLAYER_ENTRY: begin
				if (anyHeld) begin
					nextState = PLAYER_RELEASE;
				end
			end
			PLAYER_RELEASE: begin
				if (!anyHeld) begin
					nextState = PLAYER_CHECK;
				end
			end
			PLAYER_CHECK: begin
				if (!entryMatch) begin
					nextState = PLAYER_LOSE;
				end else if (roundComplete) begin
					// replay the round from its seed, one color longer
					rerunSequence = 1'b1;
					nextState = SIMON_PLAY;
				end else begin
					stepSequence = 1'b1;
					nextState = PLAYER_ENTRY;
				end
			end
			PLAYER_LOSE: begin
				nextState = IDLE;
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			playedCount <= '0;
			entryCount <= '0;
			score <= '0;
		end else begin
			state <= nextState;
			case (state)
				SIMON_PLAY: begin
					if (slotDone) begin
						playedCount <= lastSlot ? '0 : playedCount + 1'b1;
					end
				end
				PLAYER_INIT: begin
					entryCount <= '0;
				end
				PLAYER_CHECK: begin
					if (entryMatch) begin
						if (roundComplete) begin
							score <= score + 1'b1;
							entryCount <= '0;
						end else begin
							entryCount <= entryCount + 1'b1;
						end
					end
				end
				PLAYER_LOSE: begin
					score <= '0;
				end
				default: begin
				end
			endcase
		end
	end

	// color under test, captured on the first held button
	always_ff @(posedge clk) begin
		if (state == PLAYER_ENTRY && anyHeld) begin
			entryColor <= pressedColor;
		end
	end

	assign slotEnable = (state == SIMON_PLAY);
	// lamp and tone share one enable, playback window or the pressed button
	assign lampOn = (slotEnable && toneWindow) || (state == PLAYER_RELEASE);
	assign toneOn = lampOn;
	assign awaitingPlayer = (state == PLAYER_ENTRY);
	assign lampColor = (state == PLAYER_RELEASE) ? entryColor : color;

endmodule

`default_nettype wire

// ==== verilog/simonGame.sv ====
`default_nettype none

module simonGame
	import simonPkg::*;
(
	input  wire    clk,
	input  wire    reset,
	input  wire    btnTopLeft,
	input  wire    btnTopRight,
	input  wire    btnBottomLeft,
	input  wire    btnBottomRight,
	output logic   lampOn,
	output logic   toneOn,
	output color_t lampColor,
	output score_t score,
	output logic   awaitingPlayer
);

	logic heldGreen;
	logic heldRed;
	logic heldYellow;
	logic heldBlue;
	logic stepSequence;
	logic captureSeed;
	logic rerunSequence;
	logic slotEnable;
	logic slotDone;
	logic toneWindow;
	color_t color;

	// button layout: green top-left, red top-right, yellow bottom-left, blue bottom-right
	buttonDebouncer debounceGreen (
		.clk(clk),
		.reset(reset),
		.button(btnTopLeft),
		.held(heldGreen)
	);

	buttonDebouncer debounceRed (
		.clk(clk),
		.reset(reset),
		.button(btnTopRight),
		.held(heldRed)
	);

	buttonDebouncer debounceYellow (
		.clk(clk),
		.reset(reset),
		.button(btnBottomLeft),
		.held(heldYellow)
	);

	buttonDebouncer debounceBlue (
		.clk(clk),
		.reset(reset),
		.button(btnBottomRight),
		.held(heldBlue)
	);

	sequenceGenerator generator (
		.clk(clk),
		.reset(reset),
		.stepSequence(stepSequence),
		.captureSeed(captureSeed),
		.rerunSequence(rerunSequence),
		.color(color)
	);

	toneTimer timer (
		.clk(clk),
		.reset(reset),
		.slotEnable(slotEnable),
		.slotDone(slotDone),
		.toneWindow(toneWindow)
	);

	gameController controller (
		.clk(clk),
		.reset(reset),
		.heldGreen(heldGreen),
		.heldRed(heldRed),
		.heldYellow(heldYellow),
		.heldBlue(heldBlue),
		.color(color),
		.slotDone(slotDone),
		.toneWindow(toneWindow),
		.stepSequence(stepSequence),
		.captureSeed(captureSeed),
		.rerunSequence(rerunSequence),
		.slotEnable(slotEnable),
		.lampOn(lampOn),
		.toneOn(toneOn),
		.awaitingPlayer(awaitingPlayer),
		.lampColor(lampColor),
		.score(score)
	);

endmodule

`default_nettype wire

// ==== test/simonGame_chk.sv ====
`default_nettype none

module simonGame_chk
	import simonPkg::*;
(
	input wire         clk,
	input wire         reset,
	input wire         lampOn,
	input wire         awaitingPlayer,
	input wire         slotEnable,
	input wire color_t lampColor,
	input wire score_t score
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned failCount = 0;

	darkWhileWaiting: assert property (@(posedge clk) disable iff (reset)
		awaitingPlayer |-> !lampOn)
		else begin
			$error("lamp lit while waiting for the player");
			failCount++;
		end

	// score either holds, counts up by one, or clears on a loss
	scoreSteps: assert property (@(posedge clk) disable iff (reset)
		score == $past(score) || score == score_t'($past(score) + 1'b1) || score == '0)
		else begin
			$error("score jumped from %0d to %0d", $past(score), score);
			failCount++;
		end

	// the lfsr only steps in the dark part of a slot
	steadyColor: assert property (@(posedge clk) disable iff (reset)
		(slotEnable && lampOn && $past(slotEnable && lampOn)) |-> lampColor == $past(lampColor))
		else begin
			$error("lampColor changed during a lit playback period");
			failCount++;
		end

endmodule

bind gameController simonGame_chk ruleCheck (
	.clk(clk),
	.reset(reset),
	.lampOn(lampOn),
	.awaitingPlayer(awaitingPlayer),
	.slotEnable(slotEnable),
	.lampColor(lampColor),
	.score(score)
);

`default_nettype wire

// ==== test/simonGame_tb.sv ====
`default_nettype none

`include "simon_macros.svh"

module simonGame_tb
	import simonPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ToneCycles = `SIMON_TONE_CYCLES;
	localparam int OnCycles = `SIMON_TONE_ON_CYCLES;
	localparam int WaitLimit = 200;

	logic clk;
	logic reset;
	logic btnTopLeft;
	logic btnTopRight;
	logic btnBottomLeft;
	logic btnBottomRight;
	logic lampOn;
	logic toneOn;
	color_t lampColor;
	score_t score;
	logic awaitingPlayer;

	int unsigned lcgState = 32'd10051;
	// colors of the latest playback, the one before it, and the entries of this round
	color_t playback[$];
	color_t previous[$];
	color_t entered[$];
	score_t modelScore;
	logic gameOver;
	logic roundDone;

	// expectations handed to the compare process
	event compareNow;
	score_t expScore;
	logic expLamp;
	logic expAwaiting;
	logic expColorValid;
	color_t expColor;

	simonGame DUT (
		.clk(clk),
		.reset(reset),
		.btnTopLeft(btnTopLeft),
		.btnTopRight(btnTopRight),
		.btnBottomLeft(btnBottomLeft),
		.btnBottomRight(btnBottomRight),
		.lampOn(lampOn),
		.toneOn(toneOn),
		.lampColor(lampColor),
		.score(score),
		.awaitingPlayer(awaitingPlayer)
	);

	always #2 clk = ~clk;

	task automatic stopOnError(input string line);
		$display("%s", line);
		$display("tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkColor(input color_t actual, input color_t expected, input string what);
		if (actual !== expected) begin
			stopOnError($sformatf("mismatch at %0t: %s expected %s got %s", $time, what,
				expected.name(), actual.name()));
		end
	endtask

	task automatic checkScore(input score_t actual, input score_t expected, input string what);
		if (actual !== expected) begin
			stopOnError($sformatf("mismatch at %0t: %s expected %0d got %0d", $time, what,
				expected, actual));
		end
	endtask

	task automatic checkBit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			stopOnError($sformatf("mismatch at %0t: %s expected %b got %b", $time, what,
				expected, actual));
		end
	endtask

	function automatic int unsigned nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return (lcgState >> 16) & 32'h7fff;
	endfunction

	// entry priority is green, yellow, red, blue
	function automatic color_t priorityColor(input logic [3:0] mask);
		if (mask[0]) begin
			return GREEN;
		end else if (mask[2]) begin
			return YELLOW;
		end else if (mask[1]) begin
			return RED;
		end
		return BLUE;
	endfunction

	// any wrong entry ends the game, score+1 right entries finish the round
	function automatic void expectedOutcome(input score_t scoreBefore, input color_t played[$],
		input color_t typed[$], output score_t scoreAfter, output logic over);
		int i;
		scoreAfter = scoreBefore;
		over = 1'b0;
		for (i = 0; i < typed.size(); i++) begin
			if (!over && (i >= played.size() || typed[i] != played[i])) begin
				over = 1'b1;
				scoreAfter = '0;
			end
		end
		if (!over && typed.size() == int'(scoreBefore) + 1) begin
			scoreAfter = scoreBefore + 1'b1;
		end
	endfunction

	always @(compareNow) begin
		checkScore(score, expScore, "score");
		checkBit(lampOn, expLamp, "lampOn");
		checkBit(toneOn, expLamp, "toneOn");
		checkBit(awaitingPlayer, expAwaiting, "awaitingPlayer");
		if (expColorValid) begin
			checkColor(lampColor, expColor, "lampColor");
		end
	end

	task automatic requestCompare(input score_t s, input logic lamp, input logic awaiting,
		input logic colorValid, input color_t c);
		expScore = s;
		expLamp = lamp;
		expAwaiting = awaiting;
		expColorValid = colorValid;
		expColor = c;
		-> compareNow;
	endtask

	task automatic driveButtons(input logic [3:0] mask);
		btnTopLeft = mask[0];
		btnTopRight = mask[1];
		btnBottomLeft = mask[2];
		btnBottomRight = mask[3];
	endtask

	task automatic waitLamp(input logic level);
		int count;
		count = 0;
		while (lampOn !== level) begin
			@(negedge clk);
			count++;
			if (count > WaitLimit) begin
				stopOnError($sformatf("lampOn did not go to %b within %0d cycles", level, WaitLimit));
			end
		end
	endtask

	task automatic expectPlayerTurn();
		int count;
		count = 0;
		while (awaitingPlayer !== 1'b1) begin
			@(negedge clk);
			count++;
			if (count > WaitLimit) begin
				stopOnError("the game never started waiting for the player");
			end
		end
	endtask

	// starts on the first lit cycle and ends when the player is asked to enter
	task automatic recordPlayback();
		int litCycles;
		int elapsed;
		int limit;
		litCycles = 0;
		elapsed = 0;
		limit = (int'(modelScore) + 2) * ToneCycles + WaitLimit;
		playback.delete();
		while (awaitingPlayer !== 1'b1) begin
			if (lampOn) begin
				if (litCycles == 0) begin
					playback.push_back(lampColor);
				end
				litCycles++;
			end else if (litCycles != 0) begin
				if (litCycles != OnCycles) begin
					stopOnError($sformatf("mismatch at %0t: lit period of %0d cycles, expected %0d",
						$time, litCycles, OnCycles));
				end
				litCycles = 0;
			end
			elapsed++;
			if (elapsed > limit) begin
				stopOnError("playback did not hand over to the player in time");
			end
			@(negedge clk);
		end
	endtask

	task automatic startGame();
		int holdCycles;
		holdCycles = 20 + int'(nextRandom() % 40);
		driveButtons(4'b0001);
		repeat (holdCycles) @(negedge clk);
		driveButtons(4'b0000);
		waitLamp(1'b1);
		recordPlayback();
		checkScore(score_t'(playback.size()), modelScore + 1'b1, "first playback length");
		requestCompare(modelScore, 1'b0, 1'b1, 1'b0, GREEN);
	endtask

	task automatic enterButtons(input logic [3:0] mask);
		color_t pressed;
		score_t nextScore;
		logic over;
		pressed = priorityColor(mask);
		expectPlayerTurn();
		driveButtons(mask);
		waitLamp(1'b1);
		requestCompare(modelScore, 1'b1, 1'b0, 1'b1, pressed);
		repeat (4) @(negedge clk);
		driveButtons(4'b0000);
		// lamp drops for the single check cycle
		waitLamp(1'b0);
		entered.push_back(pressed);
		expectedOutcome(modelScore, playback, entered, nextScore, over);
		roundDone = !over && (nextScore != modelScore);
		gameOver = over;
		@(negedge clk);
		if (over) begin
			@(negedge clk);
		end
		requestCompare(nextScore, roundDone, !over && !roundDone, 1'b0, GREEN);
		modelScore = nextScore;
	endtask

	task automatic playRound(input logic useDouble);
		logic [3:0] mask;
		int i;
		entered.delete();
		for (i = 0; i < playback.size(); i++) begin
			mask = 4'b0001 << playback[i];
			// a second, lower-priority button must not change the entry
			if (useDouble) begin
				if (playback[i] == GREEN || playback[i] == YELLOW) begin
					mask = mask | 4'b0010;
				end else if (playback[i] == RED) begin
					mask = mask | 4'b1000;
				end
			end
			enterButtons(mask);
		end
		if (gameOver || !roundDone) begin
			stopOnError("the round did not complete after the full sequence was entered");
		end
		previous = playback;
		recordPlayback();
		checkScore(score_t'(playback.size()), modelScore + 1'b1, "playback length");
		for (i = 0; i < previous.size(); i++) begin
			checkColor(playback[i], previous[i], "replayed color");
		end
		requestCompare(modelScore, 1'b0, 1'b1, 1'b0, GREEN);
	endtask

	task automatic loseRound();
		color_t wrong;
		entered.delete();
		wrong = color_t'(2'(int'(playback[0]) + 1 + int'(nextRandom() % 3)));
		enterButtons(4'b0001 << wrong);
		if (!gameOver) begin
			stopOnError("a wrong entry did not end the game");
		end
	endtask

	initial begin
		int round;
		clk = 1'b0;
		reset = 1'b1;
		driveButtons(4'b0000);
		modelScore = '0;
		gameOver = 1'b0;
		roundDone = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		requestCompare('0, 1'b0, 1'b0, 1'b0, GREEN);
		// short green glitch must not start a game
		driveButtons(4'b0001);
		repeat (3) @(negedge clk);
		driveButtons(4'b0000);
		repeat (3 * ToneCycles) begin
			@(negedge clk);
			requestCompare('0, 1'b0, 1'b0, 1'b0, GREEN);
		end
		startGame();
		for (round = 0; round < 5; round++) begin
			playRound(round >= 2);
		end
		loseRound();
		startGame();
		playRound(1'b0);
		@(negedge clk);
		if (DUT.controller.ruleCheck.failCount == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			stopOnError($sformatf("%0d controller assertions failed",
				DUT.controller.ruleCheck.failCount));
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+verilog
verilog/simon_pkg.sv
verilog/buttonDebouncer.sv
verilog/sequenceGenerator.sv
verilog/toneTimer.sv
verilog/gameController.sv
verilog/simonGame.sv
test/simonGame_chk.sv
test/simonGame_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the Simon testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module simonGame_tb -Mdir "$BUILD_DIR" -f filelist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# assertion errors are counted by the testbench instead of stopping the run
"./$BUILD_DIR/VsimonGame_tb" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^all tests passed$" "$LOG_FILE"; then
	exit 0
else
	echo "pass line not found in $LOG_FILE"
	exit 1
fi
